//--- periph_top.f
+incdir+design
design/bus_pkg.sv
design/periph_pkg.sv
design/addr_decode.sv
design/data_ram.sv
design/timer_block.sv
design/port_io.sv
design/read_mux.sv
design/periph_top.sv
testbench/tb_clock_gen.sv
testbench/periph_top_tb.sv

//--- Bender.yml
package:
  name: periph_top

sources:
  - include_dirs:
      - design
    files:
      - design/bus_pkg.sv
      - design/periph_pkg.sv
      - design/addr_decode.sv
      - design/data_ram.sv
      - design/timer_block.sv
      - design/port_io.sv
      - design/read_mux.sv
      - design/periph_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - testbench/tb_clock_gen.sv
      - testbench/periph_top_tb.sv

//--- testbench/periph_top_tb.sv
`timescale 1ns/1ns
`include "soc_config.svh"

module periph_top_tb
    import bus_pkg::*;
    import periph_pkg::*;
();

    localparam int ticks      = `SOC_TICKS_PER_US;
    localparam int ram_words  = 8;
    localparam int ram_merges = 16;
    localparam int timer_n    = 5;
    localparam int time_gap   = 40;
    localparam int table_len  = 2 * ram_words + ram_merges + 40;
    localparam int timer_wait = (timer_n + 1) * ticks + 3;
    localparam int watchdog_cycles = table_len * 4 + 4 * timer_wait + time_gap + 200;

    // one row of the stimulus table, pins hold the model state after the row
    typedef struct packed {
        bus_req_t   req;
        button_t    buttons;
        i2c_lines_t scl_in;
        i2c_lines_t sda_in;
        bus_rsp_t   exp_rsp;
        logic       exp_led;
        i2c_lines_t exp_scl_oe;
        i2c_lines_t exp_sda_oe;
    } entry_t;

    logic       clk;
    logic       arst_n;
    bus_req_t   req;
    bus_rsp_t   rsp;
    logic       irq_ack;
    logic       irq;
    button_t    buttons;
    i2c_lines_t scl_in;
    i2c_lines_t sda_in;
    i2c_lines_t scl_oe;
    i2c_lines_t sda_oe;
    logic       led;

    entry_t     table_q [$];
    bus_rsp_t   exp_q [$];
    int         due_q [$];  // cycle each response is due in
    data_t      ram_model [1 << `SOC_RAM_BITS];
    logic       led_model;
    i2c_lines_t scl_model;
    i2c_lines_t sda_model;
    button_t    cur_buttons;
    i2c_lines_t cur_scl_in;
    i2c_lines_t cur_sda_in;
    logic [`SOC_RAM_BITS - 1:0] ram_idx [ram_words];
    bit          queue_checks;
    int          cycle;
    int          due_cycle;
    int          errors;
    int          err_start;
    int          tests_run;
    int          tests_failed;
    int unsigned seed_val;

    tb_clock_gen clock_gen_i (.clk(clk), .arst_n(arst_n));

    periph_top periph_top_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .req     (req),
        .rsp     (rsp),
        .irq_ack (irq_ack),
        .irq     (irq),
        .buttons (buttons),
        .scl_in  (scl_in),
        .sda_in  (sda_in),
        .scl_oe  (scl_oe),
        .sda_oe  (sda_oe),
        .led     (led)
    );

    always @(posedge clk) cycle <= cycle + 1;

    // responses come back in order, two cycles after the strobe
    always @(negedge clk) begin
        if (queue_checks && rsp.valid) begin
            if (exp_q.size() == 0) begin
                $display("response arrived with no read outstanding");
                errors++;
            end else begin
                due_cycle = due_q.pop_front();
                if (cycle != due_cycle) begin
                    $display("response arrived in cycle %0d, expected in cycle %0d",
                             cycle, due_cycle);
                    errors++;
                end
                check_rsp("rsp", rsp, exp_q.pop_front());
            end
        end
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout, run did not finish within %0d cycles", watchdog_cycles);
        $display("SOME TESTS FAILED");
        $finish;
    end

    // ------------------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------------------
    task automatic check_rsp(string name, bus_rsp_t got, bus_rsp_t exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_lines(string name, i2c_lines_t got, i2c_lines_t exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic end_test(string name);
        tests_run++;
        if (errors == err_start) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - err_start);
        end
        err_start = errors;
    endtask

    // ------------------------------------------------------------------------
    // table building with the reference model
    // ------------------------------------------------------------------------
    function automatic addr_t region_addr(logic [4:0] code, logic [26:0] offset);
        return {code, offset};
    endfunction

    function automatic addr_t ram_addr(logic [`SOC_RAM_BITS - 1:0] idx);
        return region_addr(`SOC_REGION_RAM, 27'(idx) << 2);
    endfunction

    function automatic bus_req_t make_req(logic write, addr_t a, data_t d, byte_en_t be);
        bus_req_t r;
        r.valid = 1'b1;
        r.write = write;
        r.addr  = a;
        r.wdata = d;
        r.be    = be;
        return r;
    endfunction

    function automatic data_t merge_lanes(data_t old, data_t d, byte_en_t be);
        data_t r;
        r = old;
        for (int lane = 0; lane < 4; lane++) begin
            if (be[lane]) r[8*lane +: 8] = d[8*lane +: 8];
        end
        return r;
    endfunction

    task automatic push_entry(bus_req_t r, bus_rsp_t e);
        entry_t en;
        en.req        = r;
        en.buttons    = cur_buttons;
        en.scl_in     = cur_scl_in;
        en.sda_in     = cur_sda_in;
        en.exp_rsp    = e;
        en.exp_led    = led_model;
        en.exp_scl_oe = ~scl_model;
        en.exp_sda_oe = ~sda_model;
        table_q.push_back(en);
    endtask

    task automatic add_idle();
        push_entry('0, '0);
    endtask

    task automatic add_write(addr_t a, data_t d, byte_en_t be);
        int p;
        p = a[`SOC_I2C_PORTS_BITS - 1:0];
        case (a[31:27])
            `SOC_REGION_RAM: begin
                ram_model[a[`SOC_RAM_BITS + 1:2]] =
                    merge_lanes(ram_model[a[`SOC_RAM_BITS + 1:2]], d, be);
            end
            `SOC_REGION_I2C: begin
                if (be[0]) begin
                    scl_model[p] = d[1];
                    sda_model[p] = d[0];
                end
            end
            `SOC_REGION_PORTS: if (be[0]) led_model = d[0];
            default: ; // dropped
        endcase
        push_entry(make_req(1'b1, a, d, be), '0);
    endtask

    task automatic add_read(addr_t a);
        bus_rsp_t e;
        int       p;
        p       = a[`SOC_I2C_PORTS_BITS - 1:0];
        e.valid = 1'b1;
        e.error = 1'b0;
        e.rdata = '0;
        case (a[31:27])
            `SOC_REGION_RAM:   e.rdata = ram_model[a[`SOC_RAM_BITS + 1:2]];
            `SOC_REGION_I2C:   e.rdata = {30'b0, cur_scl_in[p], cur_sda_in[p]};
            `SOC_REGION_PORTS: e.rdata = {27'b0, cur_buttons};
            default:           e.error = 1'b1;
        endcase
        push_entry(make_req(1'b0, a, '0, '0), e);
    endtask

    task automatic set_inputs(button_t b, i2c_lines_t s, i2c_lines_t d);
        add_idle(); // a pending read still samples the old pins
        cur_buttons = b;
        cur_scl_in  = s;
        cur_sda_in  = d;
    endtask

    // pins of a row settle two rows later
    task automatic run_table();
        entry_t e;
        entry_t prev;
        add_idle();
        add_idle();
        for (int i = 0; i < table_q.size(); i++) begin
            @(negedge clk);
            e       = table_q[i];
            req     = e.req;
            buttons = e.buttons;
            scl_in  = e.scl_in;
            sda_in  = e.sda_in;
            if (e.req.valid && !e.req.write) begin
                exp_q.push_back(e.exp_rsp);
                due_q.push_back(cycle + 2);
            end
            if (i >= 2) begin
                prev = table_q[i - 2];
                check_bit("led", led, prev.exp_led);
                check_lines("scl_oe", scl_oe, prev.exp_scl_oe);
                check_lines("sda_oe", sda_oe, prev.exp_sda_oe);
            end
        end
        table_q.delete();
        repeat (4) @(posedge clk);
        if (exp_q.size() != 0) begin
            $display("%0d read responses never arrived", exp_q.size());
            errors += exp_q.size();
            exp_q.delete();
            due_q.delete();
        end
    endtask

    // ------------------------------------------------------------------------
    // direct bus access for the timer test
    // ------------------------------------------------------------------------
    task automatic bus_write(addr_t a, data_t d, output int strobe);
        @(negedge clk);
        req    = make_req(1'b1, a, d, 4'hF);
        strobe = cycle;
        @(negedge clk);
        req = '0;
    endtask

    task automatic bus_read(addr_t a, output data_t d, output int strobe);
        bit got;
        got = 1'b0;
        d   = '0;
        @(negedge clk);
        req    = make_req(1'b0, a, '0, '0);
        strobe = cycle;
        @(negedge clk);
        req = '0;
        for (int k = 0; k < 8 && !got; k++) begin
            if (rsp.valid) begin
                d   = rsp.rdata;
                got = 1'b1;
            end else begin
                @(negedge clk);
            end
        end
        if (!got) begin
            $display("no response to a read of address %h", a);
            errors++;
        end
    endtask

    initial begin
        int    t_wr;
        int    c0;
        int    c1;
        int    elapsed;
        int    diff;
        data_t time0;
        data_t time1;
        seed_val     = $urandom(32'h9230_330e);
        req          = '0;
        irq_ack      = 1'b0;
        buttons      = '0;
        scl_in       = '1;
        sda_in       = '1;
        cur_buttons  = '0;
        cur_scl_in   = '1;
        cur_sda_in   = '1;
        led_model    = 1'b0;
        scl_model    = '1;
        sda_model    = '1;
        queue_checks = 1'b1;
        wait (arst_n === 1'b1);

        check_bit("rsp.valid", rsp.valid, 1'b0);
        check_bit("irq", irq, 1'b0);
        check_bit("led", led, 1'b0);
        check_lines("scl_oe", scl_oe, '0);
        check_lines("sda_oe", sda_oe, '0);
        end_test("reset state");

        // full words first so every merge starts from known data
        for (int k = 0; k < ram_words; k++) begin
            ram_idx[k] = $urandom_range(0, (1 << `SOC_RAM_BITS) - 1);
            add_write(ram_addr(ram_idx[k]), $urandom, 4'hF);
        end
        for (int k = 0; k < ram_merges; k++) begin
            add_write(ram_addr(ram_idx[$urandom_range(0, ram_words - 1)]), $urandom,
                      byte_en_t'($urandom_range(0, 15)));
        end
        for (int k = 0; k < ram_words; k++) add_read(ram_addr(ram_idx[k]));
        run_table();
        end_test("ram byte lanes");

        set_inputs(button_t'($urandom_range(0, 31)), i2c_lines_t'($urandom),
                   i2c_lines_t'($urandom));
        add_read(region_addr(`SOC_REGION_PORTS, '0));
        add_write(region_addr(`SOC_REGION_PORTS, '0), 32'h1, 4'h1);
        add_write(region_addr(`SOC_REGION_PORTS, '0), 32'h0, 4'hE); // led holds
        add_read(region_addr(`SOC_REGION_I2C, 27'h0));
        add_read(region_addr(`SOC_REGION_I2C, 27'h1));
        add_write(region_addr(`SOC_REGION_I2C, 27'h0), 32'h1, 4'h1); // scl 0 low
        add_write(region_addr(`SOC_REGION_I2C, 27'h1), 32'h2, 4'h1); // sda 1 low
        add_idle();
        add_write(region_addr(`SOC_REGION_I2C, 27'h0), 32'h3, 4'h1);
        set_inputs(button_t'($urandom_range(0, 31)), i2c_lines_t'($urandom),
                   i2c_lines_t'($urandom));
        add_read(region_addr(`SOC_REGION_PORTS, '0));
        add_read(region_addr(`SOC_REGION_I2C, 27'h1));
        add_write(region_addr(`SOC_REGION_PORTS, '0), 32'h0, 4'h1);
        run_table();
        end_test("ports and i2c");

        add_read(region_addr(5'h05, 27'h0));
        add_write(region_addr(5'h05, 27'(ram_idx[0]) << 2), 32'hdead_beef, 4'hF);
        add_write(region_addr(5'h00, 27'(ram_idx[1]) << 2), 32'h1234_5678, 4'hF);
        add_read(ram_addr(ram_idx[0]));
        add_read(ram_addr(ram_idx[1]));
        add_read(region_addr(5'h00, 27'h10));
        run_table();
        end_test("unmapped region");

        // ----------------------------------------------------------------------
        // timer, irq window, ack, cancel and time counter rate
        // ----------------------------------------------------------------------
        queue_checks = 1'b0;
        bus_write(region_addr(`SOC_REGION_TIMER, '0), 32'(timer_n), t_wr);
        while (!irq && (cycle - t_wr) < timer_wait + 8) @(negedge clk);
        elapsed = cycle - t_wr - 1;
        if (!irq) begin
            $display("irq did not rise after the timer write");
            errors++;
        end else if (elapsed < timer_n * ticks || elapsed > timer_wait) begin
            $display("irq rose %0d cycles after the timer write, outside the window", elapsed);
            errors++;
        end
        repeat (10) @(negedge clk);
        check_bit("irq", irq, 1'b1);
        irq_ack = 1'b1;
        @(negedge clk);
        irq_ack = 1'b0;
        check_bit("irq", irq, 1'b0);
        bus_write(region_addr(`SOC_REGION_TIMER, '0), 32'(timer_n), t_wr);
        repeat (2) @(negedge clk);
        bus_write(region_addr(`SOC_REGION_TIMER, '0), 32'h0, t_wr);
        repeat (timer_wait + 8) @(negedge clk);
        check_bit("irq", irq, 1'b0);
        bus_read(region_addr(`SOC_REGION_TIME, '0), time0, c0);
        repeat (time_gap) @(negedge clk);
        bus_read(region_addr(`SOC_REGION_TIME, '0), time1, c1);
        diff = time1 - time0;
        if (diff < (c1 - c0) / ticks - 1 || diff > (c1 - c0) / ticks + 1) begin
            $display("time counter advanced %0d us over %0d cycles", diff, c1 - c0);
            errors++;
        end
        end_test("timer");

        $display("tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- testbench/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int period_ns    = 10,
    parameter int reset_cycles = 2
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    // release between edges
    initial begin
        arst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
    end

endmodule

//--- design/periph_top.sv
`timescale 1ns/1ns

module periph_top
    import bus_pkg::*;
    import periph_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  bus_req_t   req,
    output bus_rsp_t   rsp,
    input  logic       irq_ack,
    output logic       irq,
    input  button_t    buttons,
    input  i2c_lines_t scl_in,
    input  i2c_lines_t sda_in,
    output i2c_lines_t scl_oe,
    output i2c_lines_t sda_oe,
    output logic       led
);

    dec_req_t dreq;
    dec_req_t rreq;
    data_t    ram_rdata;
    data_t    timer_rdata;
    data_t    io_rdata;

    // ------------------------------------------------------------------------
    // decode, execute, result
    // ------------------------------------------------------------------------
    addr_decode addr_decode_i (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (req),
        .dreq   (dreq),
        .rreq   (rreq)
    );

    data_ram data_ram_i (
        .clk    (clk),
        .arst_n (arst_n),
        .dreq   (dreq),
        .rdata  (ram_rdata)
    );

    timer_block timer_block_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .dreq    (dreq),
        .irq_ack (irq_ack),
        .rdata   (timer_rdata),
        .irq     (irq)
    );

    port_io port_io_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .dreq    (dreq),
        .buttons (buttons),
        .scl_in  (scl_in),
        .sda_in  (sda_in),
        .scl_oe  (scl_oe),
        .sda_oe  (sda_oe),
        .led     (led),
        .rdata   (io_rdata)
    );

    read_mux read_mux_i (
        .rreq        (rreq),
        .ram_rdata   (ram_rdata),
        .timer_rdata (timer_rdata),
        .io_rdata    (io_rdata),
        .rsp         (rsp)
    );

endmodule

//--- design/read_mux.sv
`timescale 1ns/1ns

module read_mux
    import bus_pkg::*;
(
    input  dec_req_t rreq,
    input  data_t    ram_rdata,
    input  data_t    timer_rdata,
    input  data_t    io_rdata,
    output bus_rsp_t rsp
);

    logic is_read;

    // writes get no response
    assign is_read = rreq.req.valid && !rreq.req.write;

    always_comb begin
        rsp.valid = is_read;
        rsp.error = is_read && (rreq.region == region_none);

        case (rreq.region)
            region_ram:   rsp.rdata = ram_rdata;
            region_time,
            region_timer: rsp.rdata = timer_rdata;
            region_i2c,
            region_ports: rsp.rdata = io_rdata;
            default:      rsp.rdata = '0; // unmapped
        endcase
    end

endmodule

//--- design/port_io.sv
`timescale 1ns/1ns
`include "soc_config.svh"

module port_io
    import bus_pkg::*;
    import periph_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  dec_req_t   dreq,
    input  button_t    buttons,
    input  i2c_lines_t scl_in,
    input  i2c_lines_t sda_in,
    output i2c_lines_t scl_oe,
    output i2c_lines_t sda_oe,
    output logic       led,
    output data_t      rdata
);

    i2c_lines_t                      scl_r;
    i2c_lines_t                      sda_r;
    logic [`SOC_I2C_PORTS_BITS - 1:0] port;
    logic                            ports_sel;
    logic                            i2c_sel;

    assign port      = dreq.req.addr[`SOC_I2C_PORTS_BITS - 1:0];
    assign ports_sel = dreq.req.valid && (dreq.region == region_ports);
    assign i2c_sel   = dreq.req.valid && (dreq.region == region_i2c);

    // open drain, a 0 in the register pulls the line low
    assign scl_oe = ~scl_r;
    assign sda_oe = ~sda_r;

    // ------------------------------------------------------------------------
    // led and i2c line registers
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            led   <= 1'b0;
            scl_r <= '1; // released
            sda_r <= '1;
        end else if (dreq.req.write && dreq.req.be[0]) begin
            if (ports_sel) led <= dreq.req.wdata[0];
            if (i2c_sel) begin
                scl_r[port] <= dreq.req.wdata[1];
                sda_r[port] <= dreq.req.wdata[0];
            end
        end
    end

    // sampled inputs
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rdata <= '0;
        end else if (!dreq.req.write) begin
            if (ports_sel) rdata <= {27'b0, buttons};
            else if (i2c_sel) rdata <= {30'b0, scl_in[port], sda_in[port]};
        end
    end

endmodule

//--- design/timer_block.sv
`timescale 1ns/1ns
`include "soc_config.svh"

module timer_block
    import bus_pkg::*;
    import periph_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  dec_req_t dreq,
    input  logic     irq_ack,
    output data_t    rdata,
    output logic     irq
);

    localparam int unsigned presc_w   = $clog2(`SOC_TICKS_PER_US);
    localparam int unsigned presc_max = `SOC_TICKS_PER_US - 1;

    typedef enum logic [1:0] {idle, counting, fired} timer_state_e;

    timer_state_e         state;
    logic [presc_w - 1:0] presc;
    logic                 tick;     // one cycle per microsecond
    usec_t                time_cnt;
    usec_t                remain;
    usec_t                load_val;
    logic                 load;
    logic                 rd_time;
    logic                 rd_timer;

    assign tick     = (presc == presc_w'(presc_max));
    assign load_val = usec_t'(dreq.req.wdata);
    assign load     = dreq.req.valid && dreq.req.write && (dreq.region == region_timer);
    assign rd_time  = dreq.req.valid && !dreq.req.write && (dreq.region == region_time);
    assign rd_timer = dreq.req.valid && !dreq.req.write && (dreq.region == region_timer);
    assign irq      = (state == fired);

    // ------------------------------------------------------------------------
    // prescaler and microsecond time counter
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            presc    <= '0;
            time_cnt <= '0;
        end else begin
            presc <= tick ? '0 : presc + 1'b1;
            if (tick) time_cnt <= time_cnt + 1'b1;
        end
    end

    // ------------------------------------------------------------------------
    // one-shot countdown, fires on the tick after it reaches zero
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= idle;
            remain <= '0;
        end else begin
            case (state)
                idle: begin
                    if (load && load_val != '0) begin
                        remain <= load_val;
                        state  <= counting;
                    end
                end
                counting: begin
                    if (load) begin
                        remain <= load_val;
                        if (load_val == '0) state <= idle; // cancel
                    end else if (tick) begin
                        if (remain == '0) state <= fired;
                        else remain <= remain - 1'b1;
                    end
                end
                fired: if (irq_ack) state <= idle; // held until acked
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rdata <= '0;
        end else if (rd_time) begin
            rdata <= time_cnt;
        end else if (rd_timer) begin
            rdata <= remain; // time left
        end
    end

endmodule

//--- design/data_ram.sv
`timescale 1ns/1ns
`include "soc_config.svh"

module data_ram
    import bus_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  dec_req_t dreq,
    output data_t    rdata
);

    localparam int unsigned depth = 1 << `SOC_RAM_BITS;

    data_t mem [depth];

    logic [`SOC_RAM_BITS - 1:0] word_addr;
    logic                       sel;
    logic                       wr;
    logic                       rd;

    assign word_addr = dreq.req.addr[`SOC_RAM_BITS + 1:2];
    assign sel       = dreq.req.valid && (dreq.region == region_ram);
    assign wr        = sel && dreq.req.write;
    assign rd        = sel && !dreq.req.write;

    // ------------------------------------------------------------------------
    // byte lane writes
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (wr) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (dreq.req.be[lane]) begin
                    mem[word_addr][8*lane +: 8] <= dreq.req.wdata[8*lane +: 8];
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // registered read, old word on a same-cycle write
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rdata <= '0;
        end else if (rd) begin
            rdata <= mem[word_addr];
        end
    end

endmodule

//--- design/addr_decode.sv
`timescale 1ns/1ns
`include "soc_config.svh"

module addr_decode
    import bus_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  bus_req_t req,
    output dec_req_t dreq,
    output dec_req_t rreq
);

    region_e region;

    // region select from the top five address bits
    always_comb begin
        case (req.addr[31:27])
            `SOC_REGION_RAM:   region = region_ram;
            `SOC_REGION_I2C:   region = region_i2c;
            `SOC_REGION_TIME:  region = region_time;
            `SOC_REGION_TIMER: region = region_timer;
            `SOC_REGION_PORTS: region = region_ports;
            default:           region = region_none;
        endcase
    end

    // stage one, seen by the peripherals
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dreq <= '0;
        end else begin
            dreq.req    <= req;
            dreq.region <= region;
        end
    end

    // stage two, tells the result stage what the read words belong to
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rreq <= '0;
        end else begin
            rreq <= dreq;
        end
    end

endmodule

//--- design/periph_pkg.sv
`include "soc_config.svh"

package periph_pkg;

    // ------------------------------------------------------------------------
    // pins
    // ------------------------------------------------------------------------

    // bit 4 con, 3 psh, 2 tra, 1 trb, 0 bak
    typedef logic [4:0] button_t;

    // one bit per i2c port
    typedef logic [(1 << `SOC_I2C_PORTS_BITS) - 1:0] i2c_lines_t;

    // ------------------------------------------------------------------------
    // timer values
    // ------------------------------------------------------------------------

    // microseconds, used for the time counter and the countdown
    typedef logic [31:0] usec_t;

endpackage

//--- design/bus_pkg.sv
package bus_pkg;

    typedef logic [31:0] addr_t;    // byte address
    typedef logic [31:0] data_t;
    typedef logic [3:0]  byte_en_t; // one per byte lane

    // decoded target of a request
    typedef enum logic [2:0] {
        region_ram,
        region_i2c,
        region_time,
        region_timer,
        region_ports,
        region_none
    } region_e;

    // request from the bus master, valid is a one-cycle strobe
    typedef struct packed {
        logic     valid;
        logic     write;
        addr_t    addr;
        data_t    wdata;
        byte_en_t be;
    } bus_req_t;

    // registered request with its region attached
    typedef struct packed {
        bus_req_t req;
        region_e  region;
    } dec_req_t;

    typedef struct packed {
        logic  valid;
        logic  error;
        data_t rdata;
    } bus_rsp_t;

endpackage

//--- design/soc_config.svh
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

// ----------------------------------------------------------------------------
// region codes, taken from address bits 31..27
// ----------------------------------------------------------------------------
`define SOC_REGION_RAM    5'h02
`define SOC_REGION_I2C    5'h1A
`define SOC_REGION_TIME   5'h1B
`define SOC_REGION_TIMER  5'h1C
`define SOC_REGION_PORTS  5'h1F

// ----------------------------------------------------------------------------
// sizes and rates
// ----------------------------------------------------------------------------
`define SOC_RAM_BITS       8   // word address width
`define SOC_TICKS_PER_US   4   // clk cycles per microsecond, sim value

// log2 of the i2c port count
`define SOC_I2C_PORTS_BITS 1

`endif
